// ==== axiwr_defines.svh ====
// AXI write master parameters
`ifndef AXIWR_DEFINES_SVH
`define AXIWR_DEFINES_SVH

// Bus widths
`define AXIWR_DATA_WIDTH 64
`define AXIWR_ADDR_WIDTH 32
`define AXIWR_ID_WIDTH   4

// Write data FIFO entries, power of two
`define AXIWR_FIFO_DEPTH 8

// Fixed AW attributes
// 8 bytes per beat
`define AXIWR_AWSIZE  3'b011
// INCR burst
`define AXIWR_AWBURST 2'b01
// Non-secure, unprivileged, data access
`define AXIWR_AWPROT  3'b010

`endif

// ==== axiwr_pkg.sv ====
// AXI write master types
`include "axiwr_defines.svh"

package axiwr_pkg;

    //////////////////////////////
    // Payload vectors
    //////////////////////////////

    typedef logic [`AXIWR_DATA_WIDTH-1:0]   data_t;
    typedef logic [`AXIWR_DATA_WIDTH/8-1:0] strb_t;
    typedef logic [`AXIWR_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [1:0]                     resp_t;

    //////////////////////////////
    // Address sequencer states
    //////////////////////////////

    // Idle waits for a client address, fill waits for its data beat
    typedef enum logic {
        ST_IDLE,
        ST_FILL
    } aw_state_t;

endpackage

// ==== axiwr_aw_seq.sv ====
// AXI write address sequencer
module axiwr_aw_seq (
    input  logic             clk,
    input  logic             rst,
    input  axiwr_pkg::addr_t aw_addr,
    input  logic             aw_valid,
    output logic             aw_ready,
    input  logic             w_accept,
    output logic             hold,
    output axiwr_pkg::addr_t m_axi_awaddr,
    output logic             m_axi_awvalid,
    input  logic             m_axi_awready
);
    import axiwr_pkg::*;

    aw_state_t state;
    aw_state_t state_next;
    logic      aw_ready_next;
    logic      hold_next;
    logic      awvalid_next;
    logic      aw_take;

    assign aw_take = aw_valid && aw_ready;

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        state_next    = state;
        hold_next     = 1'b1;
        aw_ready_next = 1'b0;
        // Pending AXI address clears on the slave handshake
        awvalid_next  = m_axi_awvalid && !m_axi_awready;

        case (state)
            ST_IDLE: begin
                // Offer a new slot only when no AXI address is waiting
                aw_ready_next = !awvalid_next;
                if (aw_take) begin
                    aw_ready_next = 1'b0;
                    hold_next     = 1'b0;
                    state_next    = ST_FILL;
                end
            end
            ST_FILL: begin
                hold_next = 1'b0;
                if (w_accept) begin
                    // Beat is stored, the address may go out now
                    awvalid_next = 1'b1;
                    hold_next    = 1'b1;
                    state_next   = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    //////////////////////////////
    // Registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            hold          <= 1'b1;
            aw_ready      <= 1'b0;
            m_axi_awvalid <= 1'b0;
        end else begin
            state         <= state_next;
            hold          <= hold_next;
            aw_ready      <= aw_ready_next;
            m_axi_awvalid <= awvalid_next;
        end
    end

    // Captured address stays put until the next client handshake
    always_ff @(posedge clk) begin
        if (aw_take) begin
            m_axi_awaddr <= aw_addr;
        end
    end

endmodule

// ==== axiwr_wfifo.sv ====
// Write data FIFO
`include "axiwr_defines.svh"

module axiwr_wfifo #(
    parameter int DEPTH = `AXIWR_FIFO_DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  axiwr_pkg::data_t w_data,
    input  axiwr_pkg::strb_t w_strb,
    input  logic             w_valid,
    output logic             w_ready,
    output logic             w_accept,
    input  logic             hold,
    output axiwr_pkg::data_t rd_data,
    output axiwr_pkg::strb_t rd_strb,
    output logic             rd_valid,
    input  logic             out_take
);
    import axiwr_pkg::*;

    localparam int AW = $clog2(DEPTH);

    data_t       mem_data [DEPTH];
    strb_t       mem_strb [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        rd_load;

    // Wrap bits differ but index bits match
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    // No beats while the sequencer holds the data path
    assign w_ready  = !full && !hold;
    assign w_accept = w_valid && w_ready;

    // Read stage refills when it is empty or being drained
    assign rd_load = (out_take || !rd_valid) && !empty;

    //////////////////////////////
    // Pointers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (w_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (out_take || !rd_valid) begin
                rd_valid <= !empty;
            end
            if (rd_load) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (w_accept) begin
            mem_data[wr_ptr[AW-1:0]] <= w_data;
            mem_strb[wr_ptr[AW-1:0]] <= w_strb;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (rd_load) begin
            rd_data <= mem_data[rd_ptr[AW-1:0]];
            rd_strb <= mem_strb[rd_ptr[AW-1:0]];
        end
    end

endmodule

// ==== axiwr_wout.sv ====
// AXI W channel output register
module axiwr_wout (
    input  logic             clk,
    input  logic             rst,
    input  axiwr_pkg::data_t rd_data,
    input  axiwr_pkg::strb_t rd_strb,
    input  logic             rd_valid,
    output logic             out_take,
    output axiwr_pkg::data_t m_axi_wdata,
    output axiwr_pkg::strb_t m_axi_wstrb,
    output logic             m_axi_wvalid,
    input  logic             m_axi_wready
);

    // Register frees up on a slave handshake or when it holds nothing
    assign out_take = m_axi_wready || !m_axi_wvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_axi_wvalid <= 1'b0;
        end else if (out_take) begin
            m_axi_wvalid <= rd_valid;
        end
    end

    // Payload frozen while the slave stalls
    always_ff @(posedge clk) begin
        if (out_take) begin
            m_axi_wdata <= rd_data;
            m_axi_wstrb <= rd_strb;
        end
    end

endmodule

// ==== axiwr_master.sv ====
// Buffered AXI4 single-beat write master
`include "axiwr_defines.svh"

module axiwr_master #(
    parameter int FIFO_DEPTH = `AXIWR_FIFO_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst,
    // Client side
    input  axiwr_pkg::addr_t           aw_addr,
    input  logic                       aw_valid,
    output logic                       aw_ready,
    input  axiwr_pkg::data_t           w_data,
    input  axiwr_pkg::strb_t           w_strb,
    input  logic                       w_valid,
    output logic                       w_ready,
    output axiwr_pkg::resp_t           b_resp,
    output logic                       b_valid,
    input  logic                       b_ready,
    // AXI master side
    output logic [`AXIWR_ID_WIDTH-1:0] m_axi_awid,
    output axiwr_pkg::addr_t           m_axi_awaddr,
    output logic [7:0]                 m_axi_awlen,
    output logic [2:0]                 m_axi_awsize,
    output logic [1:0]                 m_axi_awburst,
    output logic                       m_axi_awlock,
    output logic [3:0]                 m_axi_awcache,
    output logic [2:0]                 m_axi_awprot,
    output logic [3:0]                 m_axi_awqos,
    output logic [3:0]                 m_axi_awregion,
    output logic                       m_axi_awvalid,
    input  logic                       m_axi_awready,
    output axiwr_pkg::data_t           m_axi_wdata,
    output axiwr_pkg::strb_t           m_axi_wstrb,
    output logic                       m_axi_wlast,
    output logic                       m_axi_wvalid,
    input  logic                       m_axi_wready,
    input  axiwr_pkg::resp_t           m_axi_bresp,
    input  logic                       m_axi_bvalid,
    output logic                       m_axi_bready
);
    import axiwr_pkg::*;

    logic  hold;
    logic  w_accept;
    data_t rd_data;
    strb_t rd_strb;
    logic  rd_valid;
    logic  out_take;

    //////////////////////////////
    // Fixed AXI fields
    //////////////////////////////

    // Single beat, ID zero, device non-bufferable
    assign m_axi_awid     = '0;
    assign m_axi_awlen    = 8'd0;
    assign m_axi_awsize   = `AXIWR_AWSIZE;
    assign m_axi_awburst  = `AXIWR_AWBURST;
    assign m_axi_awlock   = 1'b0;
    assign m_axi_awcache  = 4'd0;
    assign m_axi_awprot   = `AXIWR_AWPROT;
    assign m_axi_awqos    = 4'd0;
    assign m_axi_awregion = 4'd0;
    assign m_axi_wlast    = 1'b1;

    // B channel passes straight through
    assign b_resp       = m_axi_bresp;
    assign b_valid      = m_axi_bvalid;
    assign m_axi_bready = b_ready;

    //////////////////////////////
    // Blocks
    //////////////////////////////

    axiwr_aw_seq aw_seq_i (
        .clk           (clk),
        .rst           (rst),
        .aw_addr       (aw_addr),
        .aw_valid      (aw_valid),
        .aw_ready      (aw_ready),
        .w_accept      (w_accept),
        .hold          (hold),
        .m_axi_awaddr  (m_axi_awaddr),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready)
    );

    axiwr_wfifo #(
        .DEPTH (FIFO_DEPTH)
    ) wfifo_i (
        .clk      (clk),
        .rst      (rst),
        .w_data   (w_data),
        .w_strb   (w_strb),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_accept (w_accept),
        .hold     (hold),
        .rd_data  (rd_data),
        .rd_strb  (rd_strb),
        .rd_valid (rd_valid),
        .out_take (out_take)
    );

    axiwr_wout wout_i (
        .clk          (clk),
        .rst          (rst),
        .rd_data      (rd_data),
        .rd_strb      (rd_strb),
        .rd_valid     (rd_valid),
        .out_take     (out_take),
        .m_axi_wdata  (m_axi_wdata),
        .m_axi_wstrb  (m_axi_wstrb),
        .m_axi_wvalid (m_axi_wvalid),
        .m_axi_wready (m_axi_wready)
    );

endmodule

// ==== axiwr_props.sv ====
// AXI handshake assertions
module axiwr_props (
    input logic             clk, rst, w_ready,
    input logic             aw_valid, aw_ready, w_valid,
    input logic             m_axi_awvalid, m_axi_awready, m_axi_wvalid, m_axi_wready,
    input axiwr_pkg::addr_t m_axi_awaddr,
    input axiwr_pkg::data_t m_axi_wdata,
    input axiwr_pkg::strb_t m_axi_wstrb
);
    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;
    logic addr_pending;

    // Client address taken, its data beat not yet
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_pending <= 1'b0;
        end else if (aw_valid && aw_ready) begin
            addr_pending <= 1'b1;
        end else if (w_valid && w_ready) begin
            addr_pending <= 1'b0;
        end
    end

    // Address stays offered and unchanged until the slave takes it
    aw_stable: assert property (@(posedge clk) disable iff (rst)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
    else begin
        fail_count++;
        $error("AW valid or address changed before its handshake");
    end

    // Same rule on the W channel
    w_stable: assert property (@(posedge clk) disable iff (rst)
        m_axi_wvalid && !m_axi_wready |=>
            m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wstrb))
    else begin
        fail_count++;
        $error("W valid or payload changed before its handshake");
    end

    // No client beat while no address is pending
    w_needs_addr: assert property (@(posedge clk) disable iff (rst) w_ready |-> addr_pending)
    else begin
        fail_count++;
        $error("w_ready high with no client address pending");
    end

endmodule

// ==== axiwr_checker.sv ====
// AXI write traffic checker
module axiwr_checker (
    input logic             clk, rst,
    input axiwr_pkg::addr_t aw_addr, m_axi_awaddr,
    input axiwr_pkg::data_t w_data, m_axi_wdata,
    input axiwr_pkg::strb_t w_strb, m_axi_wstrb,
    input axiwr_pkg::resp_t b_resp, m_axi_bresp,
    input logic [7:0]       m_axi_awlen,
    input logic [3:0]       m_axi_awid, m_axi_awcache, m_axi_awqos, m_axi_awregion,
    input logic [2:0]       m_axi_awsize, m_axi_awprot,
    input logic [1:0]       m_axi_awburst,
    input logic             m_axi_awlock,
    input logic             aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready,
    input logic             m_axi_awvalid, m_axi_awready, m_axi_wvalid, m_axi_wready,
    input logic             m_axi_wlast, m_axi_bvalid, m_axi_bready
);
    timeunit 1ns;
    timeprecision 1ps;
    import axiwr_pkg::*;

    // Expected AXI traffic, in client order
    addr_t addr_q[$];
    data_t data_q[$];
    strb_t strb_q[$];
    int    errors     = 0;
    int    w_in_count = 0;
    logic  rst_q      = 1'b0;

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("FAIL at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
    endtask

    function automatic int pending();
        return addr_q.size() + data_q.size();
    endfunction

    //////////////////////////////
    // Sampling at the rising edge
    //////////////////////////////

    always @(posedge clk) begin
        rst_q <= rst;
        // Outputs are idle once reset has taken effect
        if (rst_q) begin
            compare("aw_ready", 0, aw_ready);
            compare("m_axi_awvalid", 0, m_axi_awvalid);
            compare("m_axi_wvalid", 0, m_axi_wvalid);
            compare("w_ready", 0, w_ready);
        end
        if (!rst) begin
            if (aw_valid && aw_ready) begin
                addr_q.push_back(aw_addr);
            end
            if (w_valid && w_ready) begin
                data_q.push_back(w_data);
                strb_q.push_back(w_strb);
                w_in_count++;
            end
            if (m_axi_awvalid && m_axi_awready) begin
                if (addr_q.size() == 0) begin
                    report_error("AXI address issued with no client address queued");
                end else begin
                    compare("m_axi_awaddr", addr_q.pop_front(), m_axi_awaddr);
                end
                compare("m_axi_awlen", 0, m_axi_awlen);
                compare("m_axi_awid", 0, m_axi_awid);
                // 8 bytes per beat, INCR, unprivileged non-secure data
                compare("m_axi_awsize", 3, m_axi_awsize);
                compare("m_axi_awburst", 1, m_axi_awburst);
                compare("m_axi_awprot", 2, m_axi_awprot);
                compare("m_axi_awlock", 0, m_axi_awlock);
                compare("m_axi_awcache", 0, m_axi_awcache);
                compare("m_axi_awqos", 0, m_axi_awqos);
                compare("m_axi_awregion", 0, m_axi_awregion);
            end
            if (m_axi_wvalid && m_axi_wready) begin
                if (data_q.size() == 0) begin
                    report_error("AXI beat issued with no client beat queued");
                end else begin
                    compare("m_axi_wdata", data_q.pop_front(), m_axi_wdata);
                    compare("m_axi_wstrb", strb_q.pop_front(), m_axi_wstrb);
                end
                compare("m_axi_wlast", 1, m_axi_wlast);
            end
            // B channel is a straight pass-through
            compare("b_resp", m_axi_bresp, b_resp);
            compare("b_valid", m_axi_bvalid, b_valid);
            compare("m_axi_bready", b_ready, m_axi_bready);
        end
    end

endmodule

// ==== axiwr_tb.sv ====
// AXI write master testbench
`include "axiwr_defines.svh"

module axiwr_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import axiwr_pkg::*;

    localparam int DEPTH = `AXIWR_FIFO_DEPTH;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    addr_t      aw_addr = '0;
    addr_t      m_axi_awaddr;
    data_t      w_data = '0;
    data_t      m_axi_wdata;
    strb_t      w_strb = '0;
    strb_t      m_axi_wstrb;
    resp_t      b_resp;
    resp_t      m_axi_bresp = '0;
    logic       aw_valid = 1'b0, w_valid = 1'b0, b_ready = 1'b0;
    logic       m_axi_awready = 1'b0, m_axi_wready = 1'b0, m_axi_bvalid = 1'b0;
    logic       aw_ready, w_ready, b_valid, m_axi_awvalid, m_axi_wvalid;
    logic       m_axi_wlast, m_axi_bready, m_axi_awlock;
    logic [7:0] m_axi_awlen;
    logic [3:0] m_axi_awid, m_axi_awcache, m_axi_awqos, m_axi_awregion;
    logic [2:0] m_axi_awsize, m_axi_awprot;
    logic [1:0] m_axi_awburst;

    // Slave modes: 0 both ready, 1 random, 2 W stalled
    int          ready_mode = 0;
    bit          b_random   = 1'b0;
    logic [31:0] lfsr       = 32'd74546;
    int          tests      = 0;
    int          passed     = 0;
    int          err_start  = 0;

    axiwr_master axiwr_master_i (.*);
    axiwr_checker monitor (.*);
    bind axiwr_master axiwr_props props_i (.*);

    initial forever #20 clk = ~clk;

    //////////////////////////////
    // Random source
    //////////////////////////////

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Slave model for the ready and response inputs
    always @(negedge clk) begin
        logic [63:0] r;
        if (ready_mode == 1) begin
            take_bits(2, r);
            m_axi_awready = r[0];
            m_axi_wready  = r[1];
        end else begin
            m_axi_awready = 1'b1;
            m_axi_wready  = (ready_mode == 0);
        end
        if (b_random) begin
            take_bits(4, r);
            m_axi_bresp  = r[1:0];
            m_axi_bvalid = r[2];
            b_ready      = r[3];
        end else begin
            m_axi_bresp  = '0;
            m_axi_bvalid = 1'b0;
            b_ready      = 1'b0;
        end
    end

    //////////////////////////////
    // Client tasks
    //////////////////////////////

    function automatic int total_errors();
        return monitor.errors + axiwr_master_i.props_i.fail_count;
    endfunction

    task automatic wait_handshake(input bit is_w, input int limit, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < limit) begin
            @(posedge clk);
            ok = is_w ? (w_valid && w_ready) : (aw_valid && aw_ready);
            n++;
        end
    endtask

    // Leaves w_valid high when the beat is not taken
    task automatic write_one(input int limit, output bit beat_ok);
        logic [63:0] a, d, s;
        bit          ok;
        take_bits(32, a);
        take_bits(64, d);
        take_bits(8, s);
        beat_ok = 1'b0;
        @(negedge clk);
        aw_addr  = a[31:0];
        aw_valid = 1'b1;
        wait_handshake(1'b0, 50, ok);
        @(negedge clk);
        aw_valid = 1'b0;
        if (!ok) begin
            monitor.report_error("client address was not accepted in time");
            return;
        end
        w_data  = d;
        w_strb  = s[7:0];
        w_valid = 1'b1;
        wait_handshake(1'b1, limit, beat_ok);
        if (beat_ok) begin
            @(negedge clk);
            w_valid = 1'b0;
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (monitor.pending() != 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (monitor.pending() != 0) begin
            monitor.report_error("queued writes never appeared on the AXI side");
        end
    endtask

    task automatic run_writes(input int count);
        bit ok;
        for (int i = 0; i < count; i++) begin
            write_one(50, ok);
            if (!ok) begin
                monitor.report_error("client beat was not accepted in time");
                @(negedge clk);
                w_valid = 1'b0;
                break;
            end
        end
        wait_drain(500);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (total_errors() == err_start) begin
            passed++;
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: failed, %0d errors", tests, name, total_errors() - err_start);
        end
        err_start = total_errors();
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        bit ok;
        int count;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        run_writes(1);
        finish_test("reset and single write");
        run_writes(200);
        finish_test("stream with readies high");
        ready_mode = 1;
        run_writes(200);
        finish_test("random back-pressure");

        // FIFO plus read stage plus output register fill up
        ready_mode = 2;
        count = 0;
        ok    = 1'b1;
        while (ok && count < DEPTH + 3) begin
            write_one(20, ok);
            if (ok) begin
                count++;
            end
        end
        monitor.compare("accepted beats", DEPTH + 2, count);
        ready_mode = 0;
        if (w_valid) begin
            wait_handshake(1'b1, 50, ok);
            if (!ok) begin
                monitor.report_error("stalled beat not accepted after release");
            end
            @(negedge clk);
            w_valid = 1'b0;
        end
        wait_drain(500);
        finish_test("stalled W channel fill and drain");

        b_random = 1'b1;
        repeat (50) @(negedge clk);
        b_random = 1'b0;
        finish_test("B channel pass-through");

        // Beat offered with no address pending
        count = monitor.w_in_count;
        @(negedge clk);
        w_data  = '1;
        w_strb  = '1;
        w_valid = 1'b1;
        repeat (20) @(negedge clk);
        w_valid = 1'b0;
        monitor.compare("beats taken without address", count, monitor.w_in_count);
        wait_drain(100);
        run_writes(1);
        finish_test("beat before address");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests, passed, tests - passed, total_errors());
        if (total_errors() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
axiwr_pkg.sv
axiwr_aw_seq.sv
axiwr_wfifo.sv
axiwr_wout.sv
axiwr_master.sv
axiwr_props.sv
axiwr_checker.sv
axiwr_tb.sv

// ==== Bender.yml ====
package:
  name: axiwr

sources:
  - include_dirs:
      - .
    files:
      - axiwr_pkg.sv
      - axiwr_aw_seq.sv
      - axiwr_wfifo.sv
      - axiwr_wout.sv
      - axiwr_master.sv
  - target: test
    include_dirs:
      - .
    files:
      - axiwr_props.sv
      - axiwr_checker.sv
      - axiwr_tb.sv
